// ==== rtl/bram_geom_pkg.sv ====
`default_nettype none

// sizes of the host port, the lanes inside a host word and the banks behind them
package bram_geom_pkg;

  // host side, one wide word as a BRAM controller presents it
  localparam int HOST_WIDTH = 32;                  // host data width
  localparam int HOST_WE    = HOST_WIDTH / 8;      // one enable per host byte

  // bank side, one datum per bank row
  localparam int BANK_WIDTH = 16;                  // bank data width
  localparam int BANK_WE    = BANK_WIDTH / 8;      // one enable per bank byte

  // data packed in a host word, lsb first
  localparam int LANES     = HOST_WIDTH / BANK_WIDTH;
  localparam int LANE_BITS = $clog2(LANES);        // lane number appended below host addr

  // interleaved banks, must be a power of two
  localparam int BANKS     = 4;
  localparam int BANK_BITS = $clog2(BANKS);        // low datum index bits pick the bank

  // row field of a bank request
  // this also caps BANK_DEPTH at 1024 rows
  localparam int BANK_ADDR_MAX = 10;

  // host addr plus lane bits gives the datum index, which is bank sel plus row
  localparam int HOST_ADDR_MAX = BANK_ADDR_MAX + BANK_BITS - LANE_BITS;

  // datum index width, same on both sides of the split
  localparam int DATUM_BITS = HOST_ADDR_MAX + LANE_BITS;

  // largest bank depth the row field can address
  localparam int BANK_DEPTH_MAX = 1 << BANK_ADDR_MAX;

endpackage

`default_nettype wire

// ==== rtl/bram_port_pkg.sv ====
`default_nettype none

// request and read data bundles on both sides of the translator
package bram_port_pkg;

  import bram_geom_pkg::*;

  // host request, sampled on every clock edge with en high
  // any we bit set means write, all clear means read
  typedef struct packed {
    logic                     en;      // access strobe
    logic [HOST_WE-1:0]       we;      // byte b belongs to lane b/2
    logic [HOST_ADDR_MAX-1:0] addr;    // host word address
    logic [HOST_WIDTH-1:0]    wrdata;  // lane l in bits 16l and up
  } host_req_t;

  // request to one bank, a copy of one lane's fields
  typedef struct packed {
    logic                     en;      // bank selected by some lane
    logic [BANK_WE-1:0]       we;      // byte enables of that lane
    logic [BANK_ADDR_MAX-1:0] addr;    // row inside the bank
    logic [BANK_WIDTH-1:0]    wrdata;  // lane write datum
  } bank_req_t;

  // one bank's output register
  // the translator and the top use packed arrays of BANKS of these
  typedef logic [BANK_WIDTH-1:0] bank_rdata_t;

  // bank_req_t layout, msb to lsb:
  //   en     1 bit
  //   we     BANK_WE bits
  //   addr   BANK_ADDR_MAX bits
  //   wrdata BANK_WIDTH bits
  //
  // host_req_t layout, msb to lsb:
  //   en     1 bit
  //   we     HOST_WE bits
  //   addr   HOST_ADDR_MAX bits
  //   wrdata HOST_WIDTH bits
  //
  // a BANKS wide packed array puts bank 0 in the low bits

endpackage

`default_nettype wire

// ==== rtl/bram_bank.sv ====
`default_nettype none

// single port bank, byte writes, registered read port
// a write shows the new row on rdata_o the next cycle (write first)
module bram_bank
  import bram_geom_pkg::*;
  import bram_port_pkg::*;
#(
  parameter int BANK_DEPTH = 256  // rows, power of two up to 1024
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  bank_req_t   req_i,
  output bank_rdata_t rdata_o
);

  // row index width, at least one bit so a tiny bank still builds
  localparam int ROW_BITS = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

  logic [BANK_WIDTH-1:0] mem [BANK_DEPTH];  // storage, no reset

  logic [ROW_BITS-1:0]   row;      // addressed row
  logic [BANK_WIDTH-1:0] cur_row;  // row as stored
  logic [BANK_WIDTH-1:0] wr_row;   // row after the byte merge

  // upper addr bits are above the bank depth and ignored
  assign row     = req_i.addr[ROW_BITS-1:0];
  assign cur_row = mem[row];

  // merge the enabled bytes into the stored row
  // with we all zero this is just the stored row, i.e. a read
  always_comb begin
    wr_row = cur_row;
    for (int b = 0; b < BANK_WE; b++) begin
      if (req_i.we[b]) begin
        wr_row[8*b +: 8] = req_i.wrdata[8*b +: 8];
      end
    end
  end

  // byte lanes written separately so tools map this to byte write BRAM
  always_ff @(posedge clk_i) begin
    if (req_i.en) begin
      for (int b = 0; b < BANK_WE; b++) begin
        if (req_i.we[b]) begin
          mem[row][8*b +: 8] <= req_i.wrdata[8*b +: 8];
        end
      end
    end
  end

  // output register, loads on any enabled cycle, holds otherwise
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_o <= '0;
    end else if (req_i.en) begin
      rdata_o <= wr_row;  // write first on a write, plain read otherwise
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bram_intrf_translator.sv ====
`default_nettype none

// spreads one host access over the banks and gathers the read data back
//
// datum index = {host addr, lane}
//   low BANK_BITS pick the bank
//   the rest is the row inside that bank
// two lanes always land in two different banks, since their indexes
// differ only in the lane bit, which sits inside the bank select
module bram_intrf_translator
  import bram_geom_pkg::*;
  import bram_port_pkg::*;
#(
  parameter int BANK_DEPTH = 256  // rows per bank
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  host_req_t                    host_req_i,
  output logic [HOST_WIDTH-1:0]        host_rddata_o,
  output bank_req_t   [BANKS-1:0]      bank_req_o,
  input  bank_rdata_t [BANKS-1:0]      bank_rdata_i
);

  // only rows that exist in a bank survive the split
  localparam logic [BANK_ADDR_MAX-1:0] ROW_MASK = BANK_ADDR_MAX'(BANK_DEPTH - 1);

  // depth has to fit the row field and be a power of two
  if (BANK_DEPTH > BANK_DEPTH_MAX) begin : g_depth_too_big
    $error("bram_intrf_translator: BANK_DEPTH %0d above %0d", BANK_DEPTH, BANK_DEPTH_MAX);
  end
  if ((BANK_DEPTH & (BANK_DEPTH - 1)) != 0) begin : g_depth_not_pow2
    $error("bram_intrf_translator: BANK_DEPTH %0d not a power of two", BANK_DEPTH);
  end

  // per lane view of the host access
  logic [LANES-1:0][DATUM_BITS-1:0]    lane_idx;   // full datum index
  logic [LANES-1:0][BANK_BITS-1:0]     lane_bank;  // bank that serves the lane
  logic [LANES-1:0][BANK_ADDR_MAX-1:0] lane_row;   // row in that bank
  logic [LANES-1:0][BANKS-1:0]         lane_hot;   // one hot bank select
  logic [LANES-1:0][BANK_WE-1:0]       lane_we;    // lane byte enables
  logic [LANES-1:0][BANK_WIDTH-1:0]    lane_wr;    // lane write datum

  logic [BANKS-1:0] bank_en;  // or of the lane selects, gated by host en

  // selection of the last enabled access, steers the read data
  logic [LANES-1:0][BANK_BITS-1:0] sel_q;

  // binary bank number to one hot
  function automatic logic [BANKS-1:0] bank_onehot(input logic [BANK_BITS-1:0] bank);
    logic [BANKS-1:0] hot;
    hot       = '0;
    hot[bank] = 1'b1;
    return hot;
  endfunction

  // split the host word into lanes
  for (genvar l = 0; l < LANES; l++) begin : g_lane
    // append the lane number below the host address
    assign lane_idx[l]  = {host_req_i.addr, LANE_BITS'(l)};
    assign lane_bank[l] = lane_idx[l][BANK_BITS-1:0];
    // drop row bits beyond the bank depth
    assign lane_row[l]  = lane_idx[l][DATUM_BITS-1:BANK_BITS] & ROW_MASK;
    assign lane_hot[l]  = bank_onehot(lane_bank[l]);

    // host byte b goes to lane b/2, byte b%2
    assign lane_we[l]   = host_req_i.we[l*BANK_WE +: BANK_WE];
    assign lane_wr[l]   = host_req_i.wrdata[l*BANK_WIDTH +: BANK_WIDTH];
  end

  // bank enables, zero whenever the host is idle
  always_comb begin
    bank_en = '0;
    if (host_req_i.en) begin
      for (int l = 0; l < LANES; l++) begin
        bank_en = bank_en | lane_hot[l];
      end
    end
  end

  // bank k always carries lane k % LANES
  // a lane with an even datum index can only hit an even bank, and so on,
  // so the banks of one lane position all see that lane's fields
  for (genvar k = 0; k < BANKS; k++) begin : g_bank
    assign bank_req_o[k].en     = bank_en[k];
    assign bank_req_o[k].we     = lane_we[k % LANES];
    assign bank_req_o[k].addr   = lane_row[k % LANES];
    assign bank_req_o[k].wrdata = lane_wr[k % LANES];
  end

  // remember which bank served each lane, the data comes back next cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q <= '0;
    end else if (host_req_i.en) begin
      sel_q <= lane_bank;
    end
  end

  // gather each lane's word from its bank
  // bank regs and sel_q both hold while idle, so the result holds too
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      host_rddata_o[l*BANK_WIDTH +: BANK_WIDTH] = bank_rdata_i[sel_q[l]];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bram_multibank.sv ====
`default_nettype none

// multibank BRAM behind one wide host port
//
//   host_req_i --> translator --> bank_req[k] --> bram_bank k
//   rddata_o   <-- translator <-- bank_rdata[k] <--'
//
// read data shows up one cycle after the access and holds while idle
module bram_multibank
  import bram_geom_pkg::*;
  import bram_port_pkg::*;
#(
  parameter int BANK_DEPTH = 256  // rows per bank, passed to every block
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  host_req_t             host_req_i,
  output logic [HOST_WIDTH-1:0] rddata_o
);

  bank_req_t   [BANKS-1:0] bank_req;    // translator to banks
  bank_rdata_t [BANKS-1:0] bank_rdata;  // bank output regs to translator

  // address split and read steering
  bram_intrf_translator #(
    .BANK_DEPTH (BANK_DEPTH)
  ) translator_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .host_req_i    (host_req_i),
    .host_rddata_o (rddata_o),
    .bank_req_o    (bank_req),
    .bank_rdata_i  (bank_rdata)
  );

  // interleaved banks, bank k holds the data with index % BANKS == k
  for (genvar k = 0; k < BANKS; k++) begin : g_bank
    bram_bank #(
      .BANK_DEPTH (BANK_DEPTH)
    ) bank_inst (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .req_i   (bank_req[k]),
      .rdata_o (bank_rdata[k])
    );
  end

endmodule

`default_nettype wire

// ==== testbench/bram_multibank_chk.sv ====
`default_nettype none

// bank side checks on the translator
module bram_multibank_chk
  import bram_geom_pkg::*;
  import bram_port_pkg::*;
(
  input logic                  clk_i,
  input logic                  rst_i,
  input host_req_t             host_req_i,
  input bank_req_t [BANKS-1:0] bank_req_i
);

  logic [BANKS-1:0] bank_en;  // en bits pulled out of the requests

  always_comb begin
    for (int k = 0; k < BANKS; k++) begin
      bank_en[k] = bank_req_i[k].en;
    end
  end

  // idle host, no bank moves
  a_idle_no_enable: assert property (@(posedge clk_i) disable iff (rst_i)
    !host_req_i.en |-> bank_en == '0)
    else $error("bank enabled while host en is low");

  // each lane hits its own bank
  a_lanes_enabled: assert property (@(posedge clk_i) disable iff (rst_i)
    host_req_i.en |-> $countones(bank_en) == LANES)
    else $error("host access did not enable exactly %0d banks", LANES);

  for (genvar k = 0; k < BANKS; k++) begin : g_we
    a_bank_we: assert property (@(posedge clk_i) disable iff (rst_i)
      bank_en[k] |-> bank_req_i[k].we == host_req_i.we[(k % LANES)*BANK_WE +: BANK_WE])
      else $error("bank %0d byte enables differ from lane %0d", k, k % LANES);
  end

endmodule

// attached to every translator instance
bind bram_intrf_translator bram_multibank_chk chk_inst (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .host_req_i (host_req_i),
  .bank_req_i (bank_req_o)
);

`default_nettype wire

// ==== testbench/bram_multibank_tb.sv ====
`default_nettype none

// directed tests for the multibank BRAM against a datum level model
module bram_multibank_tb
  import bram_geom_pkg::*;
  import bram_port_pkg::*;
();

  localparam int BANK_DEPTH  = 256;
  localparam int DATA_COUNT  = BANKS * BANK_DEPTH;  // data held by all banks
  localparam int HOST_WORDS  = DATA_COUNT / LANES;  // distinct host addresses
  localparam int RESET_LIMIT = 20;                  // cycles allowed for reset release
  localparam logic [31:0] SEED = 32'h1ab3;

  logic                  clk_i;
  logic                  rst_i;
  host_req_t             host_req_i;
  logic [HOST_WIDTH-1:0] rddata_o;

  logic [BANK_WIDTH-1:0] model [DATA_COUNT];  // one entry per datum index
  logic [31:0]           rng;                 // xorshift state
  int                    errors;
  int                    tests;

  bram_multibank #(
    .BANK_DEPTH (BANK_DEPTH)
  ) bram_multibank_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .host_req_i (host_req_i),
    .rddata_o   (rddata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;  // period 10
  end

  // reset held for 3 cycles, dropped on a falling edge
  initial begin
    rst_i = 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // datum index = addr * LANES + lane, wraps at the total bank capacity
  function automatic int datum_index(input logic [HOST_ADDR_MAX-1:0] addr, input int lane);
    return (int'(addr) * LANES + lane) % DATA_COUNT;
  endfunction

  function automatic logic [HOST_WIDTH-1:0] expected_word(
    input logic [HOST_ADDR_MAX-1:0] addr
  );
    logic [HOST_WIDTH-1:0] w;
    for (int l = 0; l < LANES; l++) begin
      w[l*BANK_WIDTH +: BANK_WIDTH] = model[datum_index(addr, l)];  // lane l from its datum
    end
    return w;
  endfunction

  // host byte b lives in lane b/2, byte b%2 of that datum
  function automatic void model_write(input logic [HOST_ADDR_MAX-1:0] addr,
                                      input logic [HOST_WIDTH-1:0] data,
                                      input logic [HOST_WE-1:0] we);
    int d;
    for (int b = 0; b < HOST_WE; b++) begin
      if (we[b]) begin
        d = datum_index(addr, b / BANK_WE);
        model[d][8*(b % BANK_WE) +: 8] = data[8*b +: 8];
      end
    end
  endfunction

  // whole word fill, differs for every host address
  function automatic logic [HOST_WIDTH-1:0] fill_word(input logic [HOST_ADDR_MAX-1:0] addr);
    return {BANK_WIDTH'(addr) ^ 16'hc3a0, BANK_WIDTH'(addr * 7) ^ 16'h1e05};
  endfunction

  task automatic compare_rdata(input logic [HOST_WIDTH-1:0] exp,
                               input logic [HOST_WIDTH-1:0] got);
    if (got !== exp) begin
      errors++;
      $display("** Error rddata_o: expected %h, got %h", exp, got);
    end
  endtask

  task automatic compare_lane(input bank_rdata_t exp, input bank_rdata_t got, input int lane);
    if (got !== exp) begin
      errors++;
      $display("** Error rddata_o lane %0d: expected %h, got %h", lane, exp, got);
    end
  endtask

  // all access tasks start and end on a falling edge
  task automatic write_word(input logic [HOST_ADDR_MAX-1:0] addr,
                            input logic [HOST_WIDTH-1:0] data,
                            input logic [HOST_WE-1:0] we);
    host_req_i = '{en: 1'b1, we: we, addr: addr, wrdata: data};
    model_write(addr, data, we);
    @(posedge clk_i);  // taken here
    @(negedge clk_i);
  endtask

  task automatic read_word(input logic [HOST_ADDR_MAX-1:0] addr,
                           output logic [HOST_WIDTH-1:0] rd);
    host_req_i = '{en: 1'b1, we: '0, addr: addr, wrdata: '0};
    @(posedge clk_i);
    @(negedge clk_i);
    rd = rddata_o;  // stable half a cycle after the edge
  endtask

  task automatic check_read(input logic [HOST_ADDR_MAX-1:0] addr);
    logic [HOST_WIDTH-1:0] rd;
    read_word(addr, rd);
    compare_rdata(expected_word(addr), rd);
  endtask

  task automatic idle_cycle();
    host_req_i = '0;  // en low
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  // reset moves on falling edges, so look at it on rising ones
  task automatic wait_reset_release(output bit ok);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    while (rst_i && cycles < RESET_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    ok = !rst_i;
    @(negedge clk_i);  // back on the drive edge
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("%s: %s", name, (errors == err_before) ? "ok" : "failed");
  endtask

  task automatic reset_clears_output();
    int e;
    e = errors;
    compare_rdata('0, rddata_o);  // bank regs and stored selection all cleared
    report_test("reset value", e);
  endtask

  // every bank and both lanes, back to back
  task automatic full_word_sweep();
    int e;
    e = errors;
    for (int a = 0; a < HOST_WORDS; a++) begin
      write_word(HOST_ADDR_MAX'(a), fill_word(HOST_ADDR_MAX'(a)), '1);
    end
    for (int a = 0; a < HOST_WORDS; a++) begin
      check_read(HOST_ADDR_MAX'(a));
    end
    report_test("full words", e);
  endtask

  task automatic partial_byte_writes();
    logic [HOST_WE-1:0]       we_list [6] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                              4'b0011, 4'b1100};
    logic [HOST_ADDR_MAX-1:0] addr;
    logic [HOST_WIDTH-1:0]    rd;
    logic [HOST_WIDTH-1:0]    exp;
    int                       e;
    e = errors;
    for (int i = 0; i < 8; i++) begin
      addr = next_rand();
      foreach (we_list[j]) begin
        write_word(addr, next_rand(), we_list[j]);
        read_word(addr, rd);
        exp = expected_word(addr);
        for (int l = 0; l < LANES; l++) begin
          compare_lane(exp[l*BANK_WIDTH +: BANK_WIDTH], rd[l*BANK_WIDTH +: BANK_WIDTH], l);
        end
      end
    end
    report_test("partial writes", e);
  endtask

  // odd addresses put lane 0 on bank 2, even ones on bank 0
  task automatic alternating_bank_reads();
    int e;
    e = errors;
    for (int i = 0; i < 16; i++) begin
      check_read(HOST_ADDR_MAX'(2 * ((i * 13) % 200) + (i % 2)));
    end
    report_test("alternating reads", e);
  endtask

  task automatic idle_hold();
    logic [HOST_ADDR_MAX-1:0] addr;
    int                       e;
    e = errors;
    addr = 45;
    check_read(addr);
    for (int i = 0; i < 5; i++) begin
      idle_cycle();
      compare_rdata(expected_word(addr), rddata_o);  // still the last read
    end
    report_test("idle hold", e);
  endtask

  task automatic random_traffic();
    logic [31:0]              r;
    logic [HOST_ADDR_MAX-1:0] addr;
    logic [HOST_WE-1:0]       we;
    int                       e;
    e = errors;
    for (int i = 0; i < 200; i++) begin
      r    = next_rand();
      addr = r[HOST_ADDR_MAX-1:0];  // upper bits alias, the model wraps the same way
      if (r[31]) begin
        we = r[24 +: HOST_WE];
        if (we == '0) begin
          we = '1;  // all zero would be a read
        end
        write_word(addr, next_rand(), we);
      end else begin
        check_read(addr);
      end
    end
    report_test("random access", e);
  endtask

  initial begin : main
    bit reset_ok;
    host_req_i = '0;
    errors     = 0;
    tests      = 0;
    rng        = SEED;
    wait_reset_release(reset_ok);
    if (reset_ok) begin
      reset_clears_output();
      full_word_sweep();
      partial_byte_writes();
      alternating_bank_reads();
      idle_hold();
      random_traffic();
    end else begin
      $display("reset never released");
      errors++;
    end
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/bram_geom_pkg.sv
rtl/bram_port_pkg.sv
rtl/bram_bank.sv
rtl/bram_intrf_translator.sv
rtl/bram_multibank.sv
testbench/bram_multibank_chk.sv
testbench/bram_multibank_tb.sv
